// File: filelist.f
+incdir+include
hw/dbg_mem_pkg.sv
hw/dbg_core_bus_if.sv
hw/dbg_hart_ctrl.sv
hw/dbg_abstract_cmd_gen.sv
hw/dbg_mem_port.sv
hw/dbg_mem_top.sv
tb/dbg_mem_checker.sv
tb/dbg_mem_tb.sv

// File: hw/dbg_abstract_cmd_gen.sv
// ------------------------------
// abstract command program builder
// access register, GPR and CSR
// postexec and unsupported detection
// ------------------------------
`timescale 1ns/1ps
`include "dbg_mem_config.svh"

module dbg_abstract_cmd_gen import dbg_mem_pkg::*; (
  input  cmd_t       cmd_i,
  output abs_prog_t  prog_o,
  output logic       unsupported_o
);

  // s0 is borrowed as scratch for CSR moves
  localparam logic [4:0] REG_S0 = 5'd8;
  // zero page, x0 is the load base
  localparam logic [4:0] REG_BASE = 5'd0;
  localparam logic [11:0] DATA_OFF = `DBG_DATA_ADDR;

  ac_ar_t ac_ar;

  assign ac_ar = ac_ar_t'(cmd_i.control);

  always_comb begin : p_prog
    unsupported_o = 1'b0;
    // default program, trap unless a transfer fills it in
    prog_o[0] = illegal();
    for (int i = 1; i < 9; i++) begin
      prog_o[i] = nop();
    end
    prog_o[9] = ebreak();

    if (cmd_i.cmdtype == CMD_ACCESS_REG) begin
      // ------------------------------
      // access register
      // ------------------------------
      if (ac_ar.aarsize < 3'd3 && !ac_ar.postincrement && ac_ar.transfer) begin
        prog_o[0] = nop();
        if (ac_ar.regno[15:14] != 2'b00) begin
          // reserved range, leave right away
          prog_o[0]     = ebreak();
          unsupported_o = 1'b1;
        end else if (ac_ar.regno[12] && ac_ar.regno[5]) begin
          // no FPU transfers
          prog_o[0]     = ebreak();
          unsupported_o = 1'b1;
        end else if (ac_ar.regno[12]) begin
          // GPR, one load or store against the data base
          if (ac_ar.write) begin
            prog_o[4] = load(ac_ar.aarsize, ac_ar.regno[4:0], REG_BASE, DATA_OFF);
          end else begin
            prog_o[4] = store(ac_ar.aarsize, ac_ar.regno[4:0], REG_BASE, DATA_OFF);
          end
        end else begin
          // CSR, move through s0 and put s0 back
          prog_o[4] = csrw(CSR_DSCRATCH0, REG_S0);
          if (ac_ar.write) begin
            prog_o[5] = load(ac_ar.aarsize, REG_S0, REG_BASE, DATA_OFF);
            prog_o[6] = csrw(ac_ar.regno[11:0], REG_S0);
          end else begin
            prog_o[5] = csrr(ac_ar.regno[11:0], REG_S0);
            prog_o[6] = store(ac_ar.aarsize, REG_S0, REG_BASE, DATA_OFF);
          end
          prog_o[7] = csrr(CSR_DSCRATCH0, REG_S0);
        end
      end else if (ac_ar.aarsize >= 3'd3 || ac_ar.postincrement) begin
        // 64 bit access or autoincrement
        prog_o[0]     = ebreak();
        unsupported_o = 1'b1;
      end
      // fall through into the program buffer
      if (ac_ar.postexec && !unsupported_o) begin
        prog_o[9] = nop();
      end
    end else begin
      // quick access and memory access are not there
      prog_o[0]     = ebreak();
      unsupported_o = 1'b1;
    end
  end

endmodule

// File: hw/dbg_core_bus_if.sv
// ------------------------------
// core-side bus access
// one request strobe, no handshake
// ------------------------------
`timescale 1ns/1ps

interface dbg_core_bus_if;

  // request strobe, write when we is high
  logic        req;
  logic        we;
  // full bus address, low bits decoded downstream
  logic [31:0] addr;
  logic [31:0] wdata;
  // byte enables for data register writes
  logic [3:0]  be;

  // hart control decodes the hart-written addresses
  modport ctrl (
    input req, we, addr, wdata
  );

  // memory port handles data writes and all reads
  modport mem (
    input req, we, addr, wdata, be
  );

endinterface

// File: hw/dbg_hart_ctrl.sv
// ------------------------------
// hart control FSM
// halted and resuming flags per hart
// command error pulses
// ------------------------------
`timescale 1ns/1ps
`include "dbg_mem_config.svh"

module dbg_hart_ctrl import dbg_mem_pkg::*; (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           ndmreset_i,
  input  hartsel_t       hartsel_i,
  input  hart_vec_t      haltreq_i,
  input  hart_vec_t      resumereq_i,
  input  logic           clear_resumeack_i,
  input  logic           cmd_valid_i,
  input  logic           unsupported_i,
  dbg_core_bus_if.ctrl   bus,
  output hart_vec_t      halted_o,
  output hart_vec_t      resuming_o,
  output logic           go_o,
  output logic           resume_o,
  output logic           cmdbusy_o,
  output logic           going_o,
  output logic           cmderror_valid_o,
  output cmderr_e        cmderror_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_GO,
    ST_RESUME,
    ST_CMD_EXEC
  } state_e;

  state_e    state_d, state_q;
  hart_vec_t halted_d, halted_q;
  hart_vec_t resuming_d, resuming_q;
  logic [`DBG_ADDR_BITS-1:0] addr;
  hartsel_t  wdata_hart;
  logic      wr;
  logic      halted_wr, going_wr, resuming_wr, exception_wr;
  logic      halted_sel;

  // ------------------------------
  // hart write decode
  // ------------------------------
  assign addr         = bus.addr[`DBG_ADDR_BITS-1:0];
  // the hart puts its own index in the write data
  assign wdata_hart   = hartsel_t'(bus.wdata[1:0]);
  assign wr           = bus.req && bus.we;
  assign halted_wr    = wr && (addr == `DBG_HALTED_ADDR);
  assign going_wr     = wr && (addr == `DBG_GOING_ADDR);
  assign resuming_wr  = wr && (addr == `DBG_RESUMING_ADDR);
  assign exception_wr = wr && (addr == `DBG_EXCEPTION_ADDR);
  // selected hart reports halt again, command done
  assign halted_sel   = halted_wr && (wdata_hart == hartsel_i);

  assign going_o    = going_wr;
  assign halted_o   = halted_q;
  assign resuming_o = resuming_q;

  always_comb begin : p_flags
    halted_d   = halted_q;
    resuming_d = resuming_q;
    // debugger acknowledges the resume
    if (clear_resumeack_i) begin
      resuming_d[hartsel_i] = 1'b0;
    end
    if (halted_wr) begin
      halted_d[wdata_hart] = 1'b1;
    end
    // hart left the park loop, no longer halted
    if (resuming_wr) begin
      halted_d[wdata_hart]   = 1'b0;
      resuming_d[wdata_hart] = 1'b1;
    end
    if (ndmreset_i) begin
      halted_d   = '0;
      resuming_d = '0;
    end
  end

  // ------------------------------
  // control FSM and error pulses
  // ------------------------------
  always_comb begin : p_fsm
    state_d          = state_q;
    go_o             = 1'b0;
    resume_o         = 1'b0;
    cmdbusy_o        = 1'b1;
    cmderror_valid_o = 1'b0;
    cmderror_o       = CMD_ERR_NONE;
    case (state_q)
      ST_IDLE: begin
        cmdbusy_o = 1'b0;
        if (cmd_valid_i && halted_q[hartsel_i] && !unsupported_i) begin
          state_d = ST_GO;
        end else if (cmd_valid_i) begin
          // commands need a halted hart
          cmderror_valid_o = 1'b1;
          cmderror_o       = CMD_ERR_HALT_RESUME;
        end
        // resume only a halted hart that already cleared its ack
        if (resumereq_i[hartsel_i] && !resuming_q[hartsel_i] &&
            !haltreq_i[hartsel_i] && halted_q[hartsel_i]) begin
          state_d = ST_RESUME;
        end
      end
      ST_GO: begin
        go_o = 1'b1;
        if (going_wr) begin
          state_d = ST_CMD_EXEC;
        end
      end
      ST_RESUME: begin
        resume_o = 1'b1;
        if (resuming_q[hartsel_i]) begin
          state_d = ST_IDLE;
        end
      end
      ST_CMD_EXEC: begin
        if (halted_sel) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
    // later checks win, exception is the strongest
    if (unsupported_i && cmd_valid_i) begin
      cmderror_valid_o = 1'b1;
      cmderror_o       = CMD_ERR_NOT_SUPPORTED;
    end
    if (exception_wr) begin
      cmderror_valid_o = 1'b1;
      cmderror_o       = CMD_ERR_EXCEPTION;
    end
    if (ndmreset_i) begin
      state_d  = ST_IDLE;
      go_o     = 1'b0;
      resume_o = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      state_q    <= ST_IDLE;
      halted_q   <= '0;
      resuming_q <= '0;
    end else begin
      state_q    <= state_d;
      halted_q   <= halted_d;
      resuming_q <= resuming_d;
    end
  end

endmodule

// File: hw/dbg_mem_pkg.sv
// ------------------------------
// debug memory package
// command, error and flag types
// derived region addresses
// RISC-V instruction encoders
// ------------------------------
`include "dbg_mem_config.svh"

package dbg_mem_pkg;

  typedef logic [1:0]                        hartsel_t;
  typedef logic [`DBG_NR_HARTS-1:0]          hart_vec_t;
  typedef logic [`DBG_DATA_COUNT-1:0][31:0]  data_words_t;
  typedef logic [`DBG_PROGBUF_SIZE-1:0][31:0] progbuf_t;

  // abstract command as written to the command register
  typedef struct packed {
    logic [7:0]  cmdtype;
    logic [23:0] control;
  } cmd_t;

  // access register view of the control field
  typedef struct packed {
    logic        reserved;
    logic [2:0]  aarsize;
    logic        postincrement;
    logic        postexec;
    logic        transfer;
    logic        write;
    logic [15:0] regno;
  } ac_ar_t;

  typedef enum logic [2:0] {
    CMD_ERR_NONE          = 3'd0,
    CMD_ERR_NOT_SUPPORTED = 3'd2,
    CMD_ERR_EXCEPTION     = 3'd3,
    CMD_ERR_HALT_RESUME   = 3'd4
  } cmderr_e;

  // ten words of generated program
  typedef logic [9:0][31:0] abs_prog_t;

  localparam logic [7:0]  CMD_ACCESS_REG = 8'h00;
  localparam logic [11:0] CSR_DSCRATCH0  = 12'h7b2;

  // ------------------------------
  // derived region bases
  // ------------------------------
  localparam logic [11:0] PROGBUF_BASE = `DBG_DATA_ADDR - 4 * `DBG_PROGBUF_SIZE;
  localparam logic [11:0] ABS_CMD_BASE = PROGBUF_BASE - 12'd40;

  // ------------------------------
  // instruction encoders
  // ------------------------------
  function automatic logic [31:0] jal(logic [4:0] rd, logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  // funct3 carries the access size
  function automatic logic [31:0] load(logic [2:0] size, logic [4:0] dest,
                                       logic [4:0] base, logic [11:0] offset);
    return {offset, base, size, dest, 7'h03};
  endfunction

  function automatic logic [31:0] store(logic [2:0] size, logic [4:0] src,
                                        logic [4:0] base, logic [11:0] offset);
    return {offset[11:5], src, base, size, offset[4:0], 7'h23};
  endfunction

  // csrrw x0, csr, rs1
  function automatic logic [31:0] csrw(logic [11:0] csr, logic [4:0] rs1);
    return {csr, rs1, 3'h1, 5'h0, 7'h73};
  endfunction

  // csrrs dest, csr, x0
  function automatic logic [31:0] csrr(logic [11:0] csr, logic [4:0] dest);
    return {csr, 5'h0, 3'h2, dest, 7'h73};
  endfunction

  function automatic logic [31:0] nop();
    return 32'h0000_0013;
  endfunction

  function automatic logic [31:0] ebreak();
    return 32'h0010_0073;
  endfunction

  function automatic logic [31:0] illegal();
    return 32'h0000_0000;
  endfunction

  function automatic logic [31:0] auipc(logic [4:0] rd, logic [19:0] imm);
    return {imm, rd, 7'h17};
  endfunction

endpackage

// File: hw/dbg_mem_port.sv
// ------------------------------
// core-facing memory port
// data register write merge
// registered read decode of all regions
// ------------------------------
`timescale 1ns/1ps
`include "dbg_mem_config.svh"

module dbg_mem_port import dbg_mem_pkg::*; (
  input  logic          clk_i,
  input  logic          rst_ni,
  dbg_core_bus_if.mem   bus,
  input  hartsel_t      hartsel_i,
  input  hart_vec_t     resumereq_i,
  input  logic          go_i,
  input  logic          resume_i,
  input  logic          cmdbusy_i,
  input  cmd_t          cmd_i,
  input  abs_prog_t     prog_i,
  input  progbuf_t      progbuf_i,
  input  data_words_t   data_i,
  output data_words_t   data_o,
  output logic          data_valid_o,
  output logic [31:0]   rdata_o
);

  localparam int unsigned WA_W = `DBG_ADDR_BITS - 2;
  localparam int unsigned PB_W = $clog2(`DBG_PROGBUF_SIZE);

  typedef logic [WA_W-1:0] word_addr_t;

  // region bounds in bytes
  localparam logic [11:0] DATA_END    = `DBG_DATA_ADDR + 4 * `DBG_DATA_COUNT - 1;
  localparam logic [11:0] PROGBUF_END = `DBG_DATA_ADDR - 1;
  localparam logic [11:0] ABS_CMD_END = PROGBUF_BASE - 1;

  logic [`DBG_ADDR_BITS-1:0] addr;
  word_addr_t  word_addr, data_off;
  logic [PB_W-1:0] pb_idx;
  logic [3:0]  abs_idx;
  hartsel_t    wdata_hart;
  ac_ar_t      ac_ar;
  logic [31:0] rdata_d, rdata_q;

  assign addr       = bus.addr[`DBG_ADDR_BITS-1:0];
  assign word_addr  = addr[`DBG_ADDR_BITS-1:2];
  assign data_off   = word_addr - word_addr_t'(`DBG_DATA_ADDR >> 2);
  assign pb_idx     = PB_W'(word_addr - word_addr_t'(PROGBUF_BASE >> 2));
  assign abs_idx    = 4'(word_addr - word_addr_t'(ABS_CMD_BASE >> 2));
  assign wdata_hart = hartsel_t'(bus.wdata[1:0]);
  assign ac_ar      = ac_ar_t'(cmd_i.control);
  assign rdata_o    = rdata_q;

  // ------------------------------
  // data register writes
  // ------------------------------
  always_comb begin : p_data_write
    data_o       = data_i;
    data_valid_o = 1'b0;
    if (bus.req && bus.we && (addr inside {[`DBG_DATA_ADDR:DATA_END]})) begin
      data_valid_o = 1'b1;
      for (int dc = 0; dc < `DBG_DATA_COUNT; dc++) begin
        if (data_off == word_addr_t'(dc)) begin
          // merge byte lanes under be
          for (int b = 0; b < 4; b++) begin
            if (bus.be[b]) begin
              data_o[dc][8*b +: 8] = bus.wdata[8*b +: 8];
            end
          end
        end
      end
    end
  end

  // ------------------------------
  // read decode
  // ------------------------------
  always_comb begin : p_read
    rdata_d = rdata_q;
    if (bus.req && !bus.we) begin
      rdata_d = '0;
      case (addr) inside
        `DBG_WHERETO_ADDR: begin
          if (cmdbusy_i) begin
            // postexec without transfer goes straight to the program buffer
            if (cmd_i.cmdtype == CMD_ACCESS_REG && !ac_ar.transfer && ac_ar.postexec) begin
              rdata_d = jal(5'd0, 21'(PROGBUF_BASE) - 21'(`DBG_WHERETO_ADDR));
            end else begin
              rdata_d = jal(5'd0, 21'(ABS_CMD_BASE) - 21'(`DBG_WHERETO_ADDR));
            end
          end else if (resumereq_i[wdata_hart]) begin
            rdata_d = jal(5'd0, 21'(`DBG_RESUME_ADDR) - 21'(`DBG_WHERETO_ADDR));
          end
        end
        [`DBG_DATA_ADDR:DATA_END]: begin
          for (int dc = 0; dc < `DBG_DATA_COUNT; dc++) begin
            if (data_off == word_addr_t'(dc)) begin
              rdata_d = data_i[dc];
            end
          end
        end
        [PROGBUF_BASE:PROGBUF_END]: rdata_d = progbuf_i[pb_idx];
        [ABS_CMD_BASE:ABS_CMD_END]: rdata_d = prog_i[abs_idx];
        // harts poll here, one byte lane per hart
        [`DBG_FLAGS_BASE:`DBG_FLAGS_END]: begin
          if (word_addr - word_addr_t'(`DBG_FLAGS_BASE >> 2) == word_addr_t'(hartsel_i >> 2)) begin
            rdata_d[{hartsel_i, 3'b000} +: 8] = {6'b0, resume_i, go_i};
          end
        end
        default: rdata_d = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_rdata
    if (!rst_ni) begin
      rdata_q <= '0;
    end else begin
      rdata_q <= rdata_d;
    end
  end

endmodule

// File: hw/dbg_mem_top.sv
// ------------------------------
// debug memory top level
// bus interface, hart control,
// command builder and memory port
// ------------------------------
`timescale 1ns/1ps

module dbg_mem_top import dbg_mem_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         ndmreset_i,
  input  hartsel_t     hartsel_i,
  input  hart_vec_t    haltreq_i,
  input  hart_vec_t    resumereq_i,
  input  logic         clear_resumeack_i,
  input  progbuf_t     progbuf_i,
  input  data_words_t  data_i,
  input  logic         cmd_valid_i,
  input  cmd_t         cmd_i,
  input  logic         req_i,
  input  logic         we_i,
  input  logic [31:0]  addr_i,
  input  logic [31:0]  wdata_i,
  input  logic [3:0]   be_i,
  output hart_vec_t    debug_req_o,
  output hart_vec_t    halted_o,
  output hart_vec_t    resuming_o,
  output data_words_t  data_o,
  output logic         data_valid_o,
  output logic         cmderror_valid_o,
  output cmderr_e      cmderror_o,
  output logic         cmdbusy_o,
  output logic [31:0]  rdata_o
);

  logic      go, resume, unsupported;
  abs_prog_t prog;

  dbg_core_bus_if bus ();

  assign bus.req   = req_i;
  assign bus.we    = we_i;
  assign bus.addr  = addr_i;
  assign bus.wdata = wdata_i;
  assign bus.be    = be_i;

  // halt requests go straight to the harts
  assign debug_req_o = haltreq_i;

  dbg_hart_ctrl dbg_hart_ctrl_inst (
    .clk_i, .rst_ni, .ndmreset_i, .hartsel_i, .haltreq_i, .resumereq_i,
    .clear_resumeack_i, .cmd_valid_i,
    .unsupported_i (unsupported), .bus (bus.ctrl),
    .halted_o, .resuming_o, .go_o (go), .resume_o (resume), .cmdbusy_o,
    .going_o (), .cmderror_valid_o, .cmderror_o
  );

  dbg_abstract_cmd_gen dbg_abstract_cmd_gen_inst (
    .cmd_i, .prog_o (prog), .unsupported_o (unsupported)
  );

  dbg_mem_port dbg_mem_port_inst (
    .clk_i, .rst_ni, .bus (bus.mem), .hartsel_i, .resumereq_i,
    .go_i (go), .resume_i (resume), .cmdbusy_i (cmdbusy_o), .cmd_i,
    .prog_i (prog), .progbuf_i, .data_i, .data_o, .data_valid_o, .rdata_o
  );

endmodule

// File: include/dbg_mem_config.svh
// ------------------------------
// debug memory configuration
// hart count, data count, program buffer size
// fixed debug address map (zero page)
// ------------------------------
`ifndef DBG_MEM_CONFIG_SVH
`define DBG_MEM_CONFIG_SVH

// sizes
`define DBG_NR_HARTS       4
`define DBG_DATA_COUNT     2
`define DBG_PROGBUF_SIZE   8

// only the low bits of the bus address are decoded
`define DBG_ADDR_BITS      12

// addresses written by the hart from the debug ROM
`define DBG_HALTED_ADDR    12'h100
`define DBG_GOING_ADDR     12'h108
`define DBG_RESUMING_ADDR  12'h110
`define DBG_EXCEPTION_ADDR 12'h118

// variable jump slot and per-hart flag area
`define DBG_WHERETO_ADDR   12'h300
`define DBG_FLAGS_BASE     12'h400
`define DBG_FLAGS_END      12'h7FF

// data registers, program buffer sits right below
`define DBG_DATA_ADDR      12'h380
`define DBG_RESUME_ADDR    12'h808

`endif

// File: tb/dbg_mem_checker.sv
// ------------------------------
// port checks on the debug memory top
// error code, ndmreset, halt request
// bound into dbg_mem_top
// ------------------------------
`timescale 1ns/1ps
`include "dbg_mem_config.svh"

module dbg_mem_checker import dbg_mem_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       ndmreset_i,
  input  hart_vec_t  haltreq_i,
  input  hart_vec_t  debug_req_o,
  input  hart_vec_t  halted_o,
  input  logic       cmderror_valid_o,
  input  cmderr_e    cmderror_o
);

  // failed assertions, read back by the testbench
  int unsigned fails = 0;

  // an error pulse always names its cause
  err_has_code: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmderror_valid_o |-> cmderror_o != CMD_ERR_NONE)
  else begin
    fails++;
    $error("cmderror_valid_o high with cmderror_o none");
  end

  // ndmreset drops every halted flag on the next edge
  ndmreset_clears: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ndmreset_i |=> halted_o == `DBG_NR_HARTS'(0))
  else begin
    fails++;
    $error("halted_o still set after ndmreset_i");
  end

  // halt requests pass straight through
  halt_req_pass: assert property (@(posedge clk_i) disable iff (!rst_ni)
    debug_req_o == haltreq_i)
  else begin
    fails++;
    $error("debug_req_o differs from haltreq_i");
  end

endmodule

bind dbg_mem_top dbg_mem_checker dbg_mem_checker_inst (
  .clk_i, .rst_ni, .ndmreset_i, .haltreq_i, .debug_req_o, .halted_o,
  .cmderror_valid_o, .cmderror_o
);

// File: tb/dbg_mem_tb.sv
// ------------------------------
// debug memory testbench
// clock, reset, seeded random stimulus
// flag, FSM and program reference model
// halt/resume, commands, data, errors
// ------------------------------
`timescale 1ns/1ps
`include "dbg_mem_config.svh"

module dbg_mem_tb
  import dbg_mem_pkg::*;
();

  localparam int WAIT_LIMIT = 50;
  // program buffer right below data, command program below that
  localparam logic [31:0] PB_BASE  = `DBG_DATA_ADDR - 4 * `DBG_PROGBUF_SIZE;
  localparam logic [31:0] ABS_BASE = PB_BASE - 40;
  localparam logic [31:0] NOP_W     = 32'h0000_0013;
  localparam logic [31:0] EBREAK_W  = 32'h0010_0073;
  localparam logic [31:0] ILLEGAL_W = 32'h0000_0000;

  logic         clk_i, rst_ni, ndmreset_i, clear_resumeack_i, cmd_valid_i;
  hartsel_t     hartsel_i;
  hart_vec_t    haltreq_i, resumereq_i, debug_req_o, halted_o, resuming_o;
  progbuf_t     progbuf_i;
  data_words_t  data_i, data_o;
  cmd_t         cmd_i;
  logic         req_i, we_i, data_valid_o, cmderror_valid_o, cmdbusy_o;
  logic [31:0]  addr_i, wdata_i, rdata_o;
  logic [3:0]   be_i;
  cmderr_e      cmderror_o;

  int seed = 3852;
  int checks = 0;
  int errors = 0;
  // model state
  hart_vec_t   halted_m, resuming_m;
  logic [31:0] exp_prog [10];
  logic        exp_unsup;

  dbg_mem_top dbg_mem_top_inst (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // ------------------------------
  // instruction words from the ISA
  // ------------------------------
  function automatic logic [31:0] jump_word(input logic [31:0] target);
    logic [20:0] o;
    o = 21'(target - `DBG_WHERETO_ADDR);
    return {o[20], o[10:1], o[11], o[19:12], 5'd0, 7'b1101111};
  endfunction

  // x0 based, data base as offset
  function automatic logic [31:0] load_word(input logic [2:0] sz, input logic [4:0] rd);
    return {12'(`DBG_DATA_ADDR), 5'd0, sz, rd, 7'b0000011};
  endfunction

  function automatic logic [31:0] store_word(input logic [2:0] sz, input logic [4:0] rs);
    logic [11:0] off;
    off = 12'(`DBG_DATA_ADDR);
    return {off[11:5], rs, 5'd0, sz, off[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] csr_word(input logic [11:0] csr, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
    return {csr, rs1, f3, rd, 7'b1110011};
  endfunction

  function automatic logic [31:0] make_cmd(input logic [7:0] ty, input logic [2:0] sz,
                                           input logic pinc, input logic pexec,
                                           input logic xfer, input logic wr,
                                           input logic [15:0] regno);
    return {ty, 1'b0, sz, pinc, pexec, xfer, wr, regno};
  endfunction

  // expected ten word program and unsupported flag
  task build_prog(input logic [31:0] c);
    logic [2:0]  sz;
    logic [15:0] regno;
    sz    = c[22:20];
    regno = c[15:0];
    for (int i = 0; i < 10; i++) begin
      exp_prog[i] = NOP_W;
    end
    exp_prog[0] = ILLEGAL_W;
    exp_prog[9] = EBREAK_W;
    exp_unsup   = 1'b0;
    if (c[31:24] != 8'h00 || sz >= 3'd3 || c[19]) begin
      exp_unsup = 1'b1;
    end else if (c[17]) begin
      if (regno[15:14] != 2'b00 || (regno[12] && regno[5])) begin
        exp_unsup = 1'b1;
      end else if (regno[12]) begin
        exp_prog[0] = NOP_W;
        exp_prog[4] = c[16] ? load_word(sz, regno[4:0]) : store_word(sz, regno[4:0]);
      end else begin
        // s0 saved in dscratch0 around the move
        exp_prog[0] = NOP_W;
        exp_prog[4] = csr_word(12'h7b2, 5'd8, 3'b001, 5'd0);
        exp_prog[5] = c[16] ? load_word(sz, 5'd8) : csr_word(regno[11:0], 5'd0, 3'b010, 5'd8);
        exp_prog[6] = c[16] ? csr_word(regno[11:0], 5'd8, 3'b001, 5'd0) : store_word(sz, 5'd8);
        exp_prog[7] = csr_word(12'h7b2, 5'd0, 3'b010, 5'd8);
      end
    end
    if (exp_unsup) begin
      exp_prog[0] = EBREAK_W;
    end else if (c[18]) begin
      exp_prog[9] = NOP_W;
    end
  endtask

  // ------------------------------
  // bus and check helpers
  // ------------------------------
  task step();
    @(posedge clk_i);
    #1;
  endtask

  task expect_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task verify_flags();
    expect_word("halted_o", halted_o, halted_m);
    expect_word("resuming_o", resuming_o, resuming_m);
  endtask

  // leaves the write open so same-cycle outputs can be checked
  task drive_write(input logic [31:0] a, input logic [31:0] d, input logic [3:0] b);
    req_i   = 1'b1;
    we_i    = 1'b1;
    addr_i  = a;
    wdata_i = d;
    be_i    = b;
    #1;
  endtask

  task close_access();
    step();
    req_i = 1'b0;
    we_i  = 1'b0;
  endtask

  task read_word(input logic [31:0] a, input logic [31:0] d, output logic [31:0] q);
    req_i   = 1'b1;
    we_i    = 1'b0;
    addr_i  = a;
    wdata_i = d;
    step();
    req_i = 1'b0;
    q     = rdata_o;
  endtask

  // hart reports through one of its fixed addresses
  task hart_write(input logic [31:0] a, input int h);
    drive_write(a, h, 4'hf);
    close_access();
    if (a == `DBG_HALTED_ADDR) begin
      halted_m[h] = 1'b1;
    end else if (a == `DBG_RESUMING_ADDR) begin
      halted_m[h]   = 1'b0;
      resuming_m[h] = 1'b1;
    end
    verify_flags();
  endtask

  task send_cmd(input logic [31:0] c, input logic err, input cmderr_e code);
    cmd_i       = c;
    cmd_valid_i = 1'b1;
    #1;
    expect_word("cmderror_valid_o", cmderror_valid_o, err);
    if (err) begin
      expect_word("cmderror_o", cmderror_o, code);
    end
    step();
    cmd_valid_i = 1'b0;
  endtask

  task fail_on_timeout(input string msg);
    $display("timeout: %s", msg);
    $display("checks %0d, errors %0d, assertion failures %0d, timeouts 1",
             checks, errors, dbg_mem_top_inst.dbg_mem_checker_inst.fails);
    $display("*** FAILED ***");
    $finish;
  endtask

  task wait_busy(input logic level, input string what);
    int n;
    n = 0;
    while (cmdbusy_o !== level && n < WAIT_LIMIT) begin
      step();
      n++;
    end
    if (cmdbusy_o !== level) begin
      fail_on_timeout($sformatf("cmdbusy_o never went to %0d %s", level, what));
    end
  endtask

  // ------------------------------
  // behaviors
  // ------------------------------
  task halt_and_resume();
    int h;
    logic [31:0] q;
    hart_vec_t   hreq;
    h = $random(seed) & 3;
    hartsel_i = hartsel_t'(h);
    hart_write(`DBG_HALTED_ADDR, h);
    // halt requests pass through to the harts
    hreq = hart_vec_t'($random(seed)) | hart_vec_t'(1 << h);
    haltreq_i      = hreq;
    resumereq_i[h] = 1'b1;
    #1;
    expect_word("debug_req_o", debug_req_o, hreq);
    step();
    // pending halt request holds the FSM in idle
    expect_word("cmdbusy_o", cmdbusy_o, 1'b0);
    haltreq_i = '0;
    // FSM enters resume on this edge
    step();
    read_word(`DBG_FLAGS_BASE, 0, q);
    expect_word("rdata_o flags", q, 32'h2 << (8 * h));
    hart_write(`DBG_RESUMING_ADDR, h);
    wait_busy(1'b0, "after resuming write");
    read_word(`DBG_WHERETO_ADDR, h, q);
    expect_word("rdata_o whereto", q, jump_word(`DBG_RESUME_ADDR));
    resumereq_i[h]    = 1'b0;
    clear_resumeack_i = 1'b1;
    step();
    clear_resumeack_i = 1'b0;
    resuming_m[h] = 1'b0;
    verify_flags();
  endtask

  task reject_when_running();
    int h;
    h = $random(seed) & 3;
    while (halted_m[h]) begin
      h = (h + 1) & 3;
    end
    hartsel_i = hartsel_t'(h);
    send_cmd(make_cmd(8'h00, 3'd2, 1'b0, 1'b0, 1'b1, 1'b0, 16'h1001), 1'b1,
             CMD_ERR_HALT_RESUME);
    expect_word("cmdbusy_o", cmdbusy_o, 1'b0);
    step();
    expect_word("cmdbusy_o", cmdbusy_o, 1'b0);
  endtask

  task transfer_registers();
    int h;
    logic [31:0] c, q, target;
    logic [15:0] regno;
    repeat (12) begin
      h = $random(seed) & 3;
      hartsel_i = hartsel_t'(h);
      if (!halted_m[h]) begin
        hart_write(`DBG_HALTED_ADDR, h);
      end
      // GPR with bit 5 clear, or plain CSR number
      if ($random(seed) & 1) begin
        regno = 16'h1000 | 16'($random(seed) & 5'h1f);
      end else begin
        regno = 16'($random(seed) & 12'hfff);
      end
      c = make_cmd(8'h00, 3'($unsigned($random(seed)) % 3), 1'b0, $random(seed) & 1,
                   $random(seed) & 1, $random(seed) & 1, regno);
      build_prog(c);
      send_cmd(c, 1'b0, CMD_ERR_NONE);
      wait_busy(1'b1, "after supported command");
      read_word(`DBG_FLAGS_BASE, 0, q);
      expect_word("rdata_o flags", q, 32'h1 << (8 * h));
      target = (!c[17] && c[18]) ? PB_BASE : ABS_BASE;
      read_word(`DBG_WHERETO_ADDR, h, q);
      expect_word("rdata_o whereto", q, jump_word(target));
      for (int i = 0; i < 10; i++) begin
        read_word(ABS_BASE + 4 * i, 0, q);
        expect_word($sformatf("rdata_o abs[%0d]", i), q, exp_prog[i]);
      end
      hart_write(`DBG_GOING_ADDR, h);
      hart_write(`DBG_HALTED_ADDR, h);
      wait_busy(1'b0, "after command done");
    end
  endtask

  task access_data_progbuf();
    int w;
    logic [31:0] d, q, expv;
    logic [3:0]  b;
    for (int i = 0; i < `DBG_DATA_COUNT; i++) begin
      data_i[i] = $random(seed);
    end
    for (int i = 0; i < `DBG_PROGBUF_SIZE; i++) begin
      progbuf_i[i] = $random(seed);
    end
    repeat (8) begin
      w = $unsigned($random(seed)) % `DBG_DATA_COUNT;
      d = $random(seed);
      b = $random(seed) & 4'hf;
      drive_write(`DBG_DATA_ADDR + 4 * w, d, b);
      expect_word("data_valid_o", data_valid_o, 1'b1);
      for (int i = 0; i < `DBG_DATA_COUNT; i++) begin
        expv = data_i[i];
        // only enabled lanes of the addressed word change
        for (int k = 0; k < 4; k++) begin
          if (i == w && b[k]) begin
            expv[8*k +: 8] = d[8*k +: 8];
          end
        end
        expect_word($sformatf("data_o[%0d]", i), data_o[i], expv);
      end
      close_access();
      step();
      expect_word("data_valid_o", data_valid_o, 1'b0);
    end
    for (int i = 0; i < `DBG_DATA_COUNT; i++) begin
      read_word(`DBG_DATA_ADDR + 4 * i, 0, q);
      expect_word($sformatf("rdata_o data[%0d]", i), q, data_i[i]);
    end
    for (int i = 0; i < `DBG_PROGBUF_SIZE; i++) begin
      read_word(PB_BASE + 4 * i, 0, q);
      expect_word($sformatf("rdata_o progbuf[%0d]", i), q, progbuf_i[i]);
    end
    // read data holds without a request
    step();
    expect_word("rdata_o hold", rdata_o, q);
    read_word(32'h200, 0, q);
    expect_word("rdata_o unmapped", q, 32'h0);
  endtask

  task exercise_errors();
    int h;
    logic [31:0] q;
    logic [31:0] bad [5];
    h = $random(seed) & 3;
    hartsel_i = hartsel_t'(h);
    if (!halted_m[h]) begin
      hart_write(`DBG_HALTED_ADDR, h);
    end
    bad[0] = make_cmd(8'h00, 3'd2, 1'b0, 1'b0, 1'b1, 1'b0, 16'h4000 | 16'($random(seed) & 12'hfff));
    bad[1] = make_cmd(8'h00, 3'd2, 1'b0, 1'b0, 1'b1, 1'b1, 16'h1020 | 16'($random(seed) & 5'h1f));
    bad[2] = make_cmd(8'h00, 3'd3, 1'b0, 1'b0, 1'b1, 1'b0, 16'h1001);
    bad[3] = make_cmd(8'h00, 3'd2, 1'b1, 1'b0, 1'b1, 1'b0, 16'h1001);
    bad[4] = make_cmd(8'h01 + 8'($random(seed) & 1), 3'd2, 1'b0, 1'b0, 1'b1, 1'b0, 16'h1001);
    foreach (bad[i]) begin
      build_prog(bad[i]);
      send_cmd(bad[i], 1'b1, CMD_ERR_NOT_SUPPORTED);
      expect_word("cmdbusy_o", cmdbusy_o, 1'b0);
      read_word(ABS_BASE, 0, q);
      expect_word("rdata_o abs[0]", q, exp_prog[0]);
    end
    drive_write(`DBG_EXCEPTION_ADDR, h, 4'hf);
    expect_word("cmderror_valid_o", cmderror_valid_o, 1'b1);
    expect_word("cmderror_o", cmderror_o, CMD_ERR_EXCEPTION);
    close_access();
    // set up halted, resuming and busy state, then reset it all
    hart_write(`DBG_HALTED_ADDR, (h + 1) & 3);
    hart_write(`DBG_RESUMING_ADDR, (h + 1) & 3);
    send_cmd(make_cmd(8'h00, 3'd2, 1'b0, 1'b0, 1'b1, 1'b0, 16'h1005), 1'b0, CMD_ERR_NONE);
    wait_busy(1'b1, "before ndmreset");
    ndmreset_i = 1'b1;
    step();
    ndmreset_i = 1'b0;
    halted_m   = '0;
    resuming_m = '0;
    verify_flags();
    expect_word("cmdbusy_o", cmdbusy_o, 1'b0);
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin
    rst_ni = 1'b0;
    ndmreset_i = 1'b0;
    hartsel_i = '0;
    haltreq_i = '0;
    resumereq_i = '0;
    clear_resumeack_i = 1'b0;
    progbuf_i = '0;
    data_i = '0;
    cmd_valid_i = 1'b0;
    cmd_i = '0;
    req_i = 1'b0;
    we_i = 1'b0;
    addr_i = '0;
    wdata_i = '0;
    be_i = '0;
    halted_m = '0;
    resuming_m = '0;
    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    expect_word("cmdbusy_o", cmdbusy_o, 1'b0);
    expect_word("cmderror_valid_o", cmderror_valid_o, 1'b0);
    expect_word("data_valid_o", data_valid_o, 1'b0);
    expect_word("rdata_o", rdata_o, 32'h0);
    verify_flags();
    halt_and_resume();
    reject_when_running();
    transfer_registers();
    access_data_progbuf();
    exercise_errors();
    step();
    $display("checks %0d, errors %0d, assertion failures %0d, timeouts 0",
             checks, errors, dbg_mem_top_inst.dbg_mem_checker_inst.fails);
    if (errors == 0 && dbg_mem_top_inst.dbg_mem_checker_inst.fails == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule
